// File: logic/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// datapath width, also the instruction word width
`define CPU_DATA_WIDTH 16

// eight architectural registers
`define CPU_REG_ADDR_BITS 3

// instruction memory, 64 words
`define CPU_IMEM_ADDR_BITS 6

// data memory, 64 words
`define CPU_DMEM_ADDR_BITS 6

// zero-extended immediate, doubles as the absolute branch/jump target
`define CPU_IMM_BITS 6

`endif

// File: logic/isa_pkg.sv
`default_nettype none
`include "cpu_settings.svh"

package isa_pkg;

  typedef logic [`CPU_DATA_WIDTH-1:0]     data_t;
  typedef logic [`CPU_DATA_WIDTH-1:0]     inst_t;
  typedef logic [`CPU_REG_ADDR_BITS-1:0]  reg_idx_t;
  typedef logic [`CPU_IMEM_ADDR_BITS-1:0] pc_t;
  typedef logic [`CPU_IMM_BITS-1:0]       imm_t;

  typedef enum logic [3:0] {
    OP_NOP  = 4'd0,
    OP_ADD  = 4'd1,
    OP_SUB  = 4'd2,
    OP_AND  = 4'd3,
    OP_OR   = 4'd4,
    OP_SLT  = 4'd5,
    OP_ADDI = 4'd6,
    OP_LW   = 4'd7,
    OP_SW   = 4'd8,
    OP_BEQ  = 4'd9,
    OP_BNE  = 4'd10,
    OP_J    = 4'd11,
    OP_HALT = 4'd12
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT
  } alu_op_e;

  typedef enum logic [1:0] {
    MEM_NONE,
    MEM_READ,
    MEM_WRITE
  } mem_op_e;

  typedef struct packed {
    logic    reg_write;
    mem_op_e mem_op;
    alu_op_e alu_op;
    logic    alu_src_imm;
    logic    beq;
    logic    bne;
    logic    halt;
  } ctrl_t;

  //////////////////////////////////////////////////
  // instruction fields
  //////////////////////////////////////////////////

  // op[15:12] rs[11:9] rt[8:6] rd[5:3], imm overlaps rd in [5:0]
  localparam int OPCODE_LSB = 12;
  localparam int RS_LSB     = 9;
  localparam int RT_LSB     = 6;
  localparam int RD_LSB     = 3;
  localparam int IMM_LSB    = 0;

  function automatic opcode_e inst_opcode(input inst_t inst);
    return opcode_e'(inst[OPCODE_LSB +: 4]);
  endfunction

  function automatic reg_idx_t inst_rs(input inst_t inst);
    return inst[RS_LSB +: `CPU_REG_ADDR_BITS];
  endfunction

  function automatic reg_idx_t inst_rt(input inst_t inst);
    return inst[RT_LSB +: `CPU_REG_ADDR_BITS];
  endfunction

  function automatic reg_idx_t inst_rd(input inst_t inst);
    return inst[RD_LSB +: `CPU_REG_ADDR_BITS];
  endfunction

  function automatic imm_t inst_imm(input inst_t inst);
    return inst[IMM_LSB +: `CPU_IMM_BITS];
  endfunction

endpackage

`default_nettype wire

// File: logic/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

  // fetch to decode
  typedef struct packed {
    logic           valid;
    isa_pkg::pc_t   pc;
    isa_pkg::inst_t inst;
  } if_id_t;

  // decode to execute, operands as read from the register file
  typedef struct packed {
    logic              valid;
    isa_pkg::ctrl_t    ctrl;
    isa_pkg::reg_idx_t rs;
    isa_pkg::reg_idx_t rt;
    isa_pkg::reg_idx_t dest;
    isa_pkg::data_t    rs_data;
    isa_pkg::data_t    rt_data;
    isa_pkg::imm_t     imm;
  } id_ex_t;

  // execute to memory
  typedef struct packed {
    logic              valid;
    logic              reg_write;
    isa_pkg::mem_op_e  mem_op;
    logic              halt;
    isa_pkg::reg_idx_t dest;
    isa_pkg::data_t    alu_result;
    isa_pkg::data_t    store_data;
  } ex_mem_t;

  // memory to writeback
  typedef struct packed {
    logic              valid;
    logic              reg_write;
    logic              halt;
    isa_pkg::reg_idx_t dest;
    isa_pkg::data_t    result;
  } mem_wb_t;

  // operand source for the execute stage
  typedef enum logic [1:0] {
    FWD_REGFILE,
    FWD_FROM_MEM,
    FWD_FROM_WB
  } fwd_sel_e;

endpackage

`default_nettype wire

// File: logic/fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_settings.svh"

module fetch_unit (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             stall,
  input  logic             redirect,
  input  isa_pkg::pc_t     redirect_pc,
  input  logic             prog_we,
  input  isa_pkg::pc_t     prog_addr,
  input  isa_pkg::inst_t   prog_data,
  output pipe_pkg::if_id_t if_id
);

  localparam int IMEM_WORDS = 2**`CPU_IMEM_ADDR_BITS;

  isa_pkg::inst_t imem [IMEM_WORDS];
  isa_pkg::pc_t   pc;
  isa_pkg::pc_t   pc_next;
  isa_pkg::inst_t fetched;
  logic           jump;

  // program load, only while the core sits in reset
  always_ff @(posedge clk) begin
    if (!rst_n && prog_we) begin
      imem[prog_addr] <= prog_data;
    end
  end

  assign fetched = imem[pc];

  // j is caught one stage in, costs a single bubble
  assign jump = if_id.valid && (isa_pkg::inst_opcode(if_id.inst) == isa_pkg::OP_J);

  // taken branch beats jump beats stall
  always_comb begin
    if (redirect) begin
      pc_next = redirect_pc;
    end else if (jump) begin
      pc_next = isa_pkg::pc_t'(isa_pkg::inst_imm(if_id.inst));
    end else if (stall) begin
      pc_next = pc;
    end else begin
      pc_next = pc + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc    <= '0;
      if_id <= '0;
    end else begin
      pc <= pc_next;
      if (redirect || jump) begin
        if_id <= '0;
      end else if (!stall) begin
        if_id.valid <= 1'b1;
        if_id.pc    <= pc;
        if_id.inst  <= fetched;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/register_file.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_settings.svh"

module register_file (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              we,
  input  isa_pkg::reg_idx_t waddr,
  input  isa_pkg::data_t    wdata,
  input  isa_pkg::reg_idx_t raddr_a,
  input  isa_pkg::reg_idx_t raddr_b,
  output isa_pkg::data_t    rdata_a,
  output isa_pkg::data_t    rdata_b,
  input  isa_pkg::reg_idx_t dbg_addr,
  output isa_pkg::data_t    dbg_data
);

  localparam int NUM_REGS = 2**`CPU_REG_ADDR_BITS;

  isa_pkg::data_t regs [NUM_REGS];
  logic           wr_live;

  // r0 is never written, so it reads back zero
  assign wr_live = we && (waddr != '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[waddr] <= wdata;
    end
  end

  // writeback in the same cycle is seen by decode
  assign rdata_a = (wr_live && (waddr == raddr_a)) ? wdata : regs[raddr_a];
  assign rdata_b = (wr_live && (waddr == raddr_b)) ? wdata : regs[raddr_b];

  assign dbg_data = regs[dbg_addr];

endmodule

`default_nettype wire

// File: logic/decode_unit.sv
`timescale 1ns/10ps
`default_nettype none

module decode_unit (
  input  logic              clk,
  input  logic              rst_n,
  input  pipe_pkg::if_id_t  if_id,
  input  logic              redirect,
  input  isa_pkg::data_t    rdata_a,
  input  isa_pkg::data_t    rdata_b,
  output isa_pkg::reg_idx_t raddr_a,
  output isa_pkg::reg_idx_t raddr_b,
  output logic              stall,
  output pipe_pkg::id_ex_t  id_ex
);

  isa_pkg::opcode_e  opcode;
  isa_pkg::reg_idx_t rs;
  isa_pkg::reg_idx_t rt;
  isa_pkg::reg_idx_t dest;
  isa_pkg::ctrl_t    ctrl;
  logic              uses_rs;
  logic              uses_rt;
  logic              load_use;
  logic              halt_seen;

  assign opcode  = isa_pkg::inst_opcode(if_id.inst);
  assign rs      = isa_pkg::inst_rs(if_id.inst);
  assign rt      = isa_pkg::inst_rt(if_id.inst);
  assign raddr_a = rs;
  assign raddr_b = rt;

  //////////////////////////////////////////////////
  // control decode
  //////////////////////////////////////////////////

  always_comb begin
    ctrl    = '0;
    uses_rs = 1'b0;
    uses_rt = 1'b0;
    dest    = '0;
    case (opcode)
      isa_pkg::OP_ADD,
      isa_pkg::OP_SUB,
      isa_pkg::OP_AND,
      isa_pkg::OP_OR,
      isa_pkg::OP_SLT: begin
        ctrl.reg_write = 1'b1;
        uses_rs        = 1'b1;
        uses_rt        = 1'b1;
        dest           = isa_pkg::inst_rd(if_id.inst);
        case (opcode)
          isa_pkg::OP_SUB: ctrl.alu_op = isa_pkg::ALU_SUB;
          isa_pkg::OP_AND: ctrl.alu_op = isa_pkg::ALU_AND;
          isa_pkg::OP_OR:  ctrl.alu_op = isa_pkg::ALU_OR;
          isa_pkg::OP_SLT: ctrl.alu_op = isa_pkg::ALU_SLT;
          default:         ctrl.alu_op = isa_pkg::ALU_ADD;
        endcase
      end
      isa_pkg::OP_ADDI: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        uses_rs          = 1'b1;
        dest             = rt;
      end
      isa_pkg::OP_LW: begin
        ctrl.reg_write   = 1'b1;
        ctrl.mem_op      = isa_pkg::MEM_READ;
        ctrl.alu_src_imm = 1'b1;
        uses_rs          = 1'b1;
        dest             = rt;
      end
      isa_pkg::OP_SW: begin
        ctrl.mem_op      = isa_pkg::MEM_WRITE;
        ctrl.alu_src_imm = 1'b1;
        uses_rs          = 1'b1;
        uses_rt          = 1'b1;
      end
      isa_pkg::OP_BEQ: begin
        ctrl.beq = 1'b1;
        uses_rs  = 1'b1;
        uses_rt  = 1'b1;
      end
      isa_pkg::OP_BNE: begin
        ctrl.bne = 1'b1;
        uses_rs  = 1'b1;
        uses_rt  = 1'b1;
      end
      isa_pkg::OP_HALT: ctrl.halt = 1'b1;
      // nop, j (taken in fetch) and unused codes
      default: ctrl = '0;
    endcase
    // r0 writes are dropped here and never retire
    if (dest == '0) begin
      ctrl.reg_write = 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // hazards and ID/EX
  //////////////////////////////////////////////////

  // load result is one cycle too late for the consumer right behind it
  assign load_use = if_id.valid && id_ex.valid
                    && (id_ex.ctrl.mem_op == isa_pkg::MEM_READ) && id_ex.ctrl.reg_write
                    && ((uses_rs && (id_ex.dest == rs)) || (uses_rt && (id_ex.dest == rt)));

  // after halt, fetch stays frozen
  assign stall = load_use || halt_seen;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      id_ex     <= '0;
      halt_seen <= 1'b0;
    end else begin
      if (if_id.valid && ctrl.halt && !stall && !redirect) begin
        halt_seen <= 1'b1;
      end
      if (stall || redirect || !if_id.valid) begin
        id_ex <= '0;
      end else begin
        id_ex.valid   <= 1'b1;
        id_ex.ctrl    <= ctrl;
        id_ex.rs      <= rs;
        id_ex.rt      <= rt;
        id_ex.dest    <= dest;
        id_ex.rs_data <= rdata_a;
        id_ex.rt_data <= rdata_b;
        id_ex.imm     <= isa_pkg::inst_imm(if_id.inst);
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/execute_unit.sv
`timescale 1ns/10ps
`default_nettype none

module execute_unit (
  input  logic              clk,
  input  logic              rst_n,
  input  pipe_pkg::id_ex_t  id_ex,
  input  pipe_pkg::mem_wb_t mem_wb,
  output logic              redirect,
  output isa_pkg::pc_t      redirect_pc,
  output pipe_pkg::ex_mem_t ex_mem
);

  pipe_pkg::fwd_sel_e fwd_a;
  pipe_pkg::fwd_sel_e fwd_b;
  isa_pkg::data_t     opnd_a;
  isa_pkg::data_t     opnd_b;
  isa_pkg::data_t     alu_in_b;
  isa_pkg::data_t     alu_out;
  logic               operands_equal;

  //////////////////////////////////////////////////
  // forwarding
  //////////////////////////////////////////////////

  // the younger producer in EX/MEM wins
  function automatic pipe_pkg::fwd_sel_e pick_source(
    input isa_pkg::reg_idx_t src,
    input pipe_pkg::ex_mem_t mem_item,
    input pipe_pkg::mem_wb_t wb_item
  );
    if (mem_item.valid && mem_item.reg_write && (mem_item.dest == src)) begin
      return pipe_pkg::FWD_FROM_MEM;
    end else if (wb_item.valid && wb_item.reg_write && (wb_item.dest == src)) begin
      return pipe_pkg::FWD_FROM_WB;
    end
    return pipe_pkg::FWD_REGFILE;
  endfunction

  function automatic isa_pkg::data_t forward_value(
    input pipe_pkg::fwd_sel_e sel,
    input isa_pkg::data_t     rf_data,
    input isa_pkg::data_t     mem_data,
    input isa_pkg::data_t     wb_data
  );
    case (sel)
      pipe_pkg::FWD_FROM_MEM: return mem_data;
      pipe_pkg::FWD_FROM_WB:  return wb_data;
      default:                return rf_data;
    endcase
  endfunction

  assign fwd_a  = pick_source(id_ex.rs, ex_mem, mem_wb);
  assign fwd_b  = pick_source(id_ex.rt, ex_mem, mem_wb);
  assign opnd_a = forward_value(fwd_a, id_ex.rs_data, ex_mem.alu_result, mem_wb.result);
  assign opnd_b = forward_value(fwd_b, id_ex.rt_data, ex_mem.alu_result, mem_wb.result);

  //////////////////////////////////////////////////
  // ALU and branch
  //////////////////////////////////////////////////

  // immediate is zero-extended
  assign alu_in_b = id_ex.ctrl.alu_src_imm ? isa_pkg::data_t'(id_ex.imm) : opnd_b;

  always_comb begin
    case (id_ex.ctrl.alu_op)
      isa_pkg::ALU_SUB: alu_out = opnd_a - alu_in_b;
      isa_pkg::ALU_AND: alu_out = opnd_a & alu_in_b;
      isa_pkg::ALU_OR:  alu_out = opnd_a | alu_in_b;
      // signed compare
      isa_pkg::ALU_SLT: alu_out = isa_pkg::data_t'($signed(opnd_a) < $signed(alu_in_b));
      default:          alu_out = opnd_a + alu_in_b;
    endcase
  end

  assign operands_equal = (opnd_a == opnd_b);

  assign redirect = id_ex.valid
                    && ((id_ex.ctrl.beq && operands_equal)
                        || (id_ex.ctrl.bne && !operands_equal));

  // absolute target
  assign redirect_pc = isa_pkg::pc_t'(id_ex.imm);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_mem <= '0;
    end else begin
      ex_mem.valid      <= id_ex.valid;
      ex_mem.reg_write  <= id_ex.valid && id_ex.ctrl.reg_write;
      ex_mem.mem_op     <= id_ex.valid ? id_ex.ctrl.mem_op : isa_pkg::MEM_NONE;
      ex_mem.halt       <= id_ex.valid && id_ex.ctrl.halt;
      ex_mem.dest       <= id_ex.dest;
      ex_mem.alu_result <= alu_out;
      ex_mem.store_data <= opnd_b;
    end
  end

endmodule

`default_nettype wire

// File: logic/memory_unit.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_settings.svh"

module memory_unit (
  input  logic              clk,
  input  logic              rst_n,
  input  pipe_pkg::ex_mem_t ex_mem,
  output pipe_pkg::mem_wb_t mem_wb,
  output logic              halted
);

  localparam int DMEM_WORDS = 2**`CPU_DMEM_ADDR_BITS;

  isa_pkg::data_t                 dmem [DMEM_WORDS];
  logic [`CPU_DMEM_ADDR_BITS-1:0] dmem_addr;
  isa_pkg::data_t                 load_data;
  logic                           store_en;

  // word address, upper ALU bits ignored
  assign dmem_addr = ex_mem.alu_result[`CPU_DMEM_ADDR_BITS-1:0];
  assign store_en  = ex_mem.valid && (ex_mem.mem_op == isa_pkg::MEM_WRITE);
  assign load_data = dmem[dmem_addr];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < DMEM_WORDS; i++) begin
        dmem[i] <= '0;
      end
    end else if (store_en) begin
      dmem[dmem_addr] <= ex_mem.store_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_wb <= '0;
      halted <= 1'b0;
    end else begin
      mem_wb.valid     <= ex_mem.valid;
      mem_wb.reg_write <= ex_mem.reg_write;
      mem_wb.halt      <= ex_mem.halt;
      mem_wb.dest      <= ex_mem.dest;
      mem_wb.result    <= (ex_mem.mem_op == isa_pkg::MEM_READ) ? load_data : ex_mem.alu_result;
      // sticky until reset
      if (ex_mem.valid && ex_mem.halt) begin
        halted <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/processor.sv
`timescale 1ns/10ps
`default_nettype none

module processor (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              prog_we,
  input  isa_pkg::pc_t      prog_addr,
  input  isa_pkg::inst_t    prog_data,
  input  isa_pkg::reg_idx_t dbg_addr,
  output isa_pkg::data_t    dbg_data,
  output logic              wb_valid,
  output isa_pkg::reg_idx_t wb_reg,
  output isa_pkg::data_t    wb_data,
  output logic              halted
);

  pipe_pkg::if_id_t  if_id;
  pipe_pkg::id_ex_t  id_ex;
  pipe_pkg::ex_mem_t ex_mem;
  pipe_pkg::mem_wb_t mem_wb;

  logic              stall;
  logic              redirect;
  isa_pkg::pc_t      redirect_pc;
  isa_pkg::reg_idx_t raddr_a;
  isa_pkg::reg_idx_t raddr_b;
  isa_pkg::data_t    rdata_a;
  isa_pkg::data_t    rdata_b;
  logic              rf_we;

  // retiring write, also the observable writeback event
  assign rf_we    = mem_wb.valid && mem_wb.reg_write;
  assign wb_valid = rf_we;
  assign wb_reg   = mem_wb.dest;
  assign wb_data  = mem_wb.result;

  //////////////////////////////////////////////////
  // stages
  //////////////////////////////////////////////////

  fetch_unit fetch_stage (
    .clk         (clk),
    .rst_n       (rst_n),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .prog_we     (prog_we),
    .prog_addr   (prog_addr),
    .prog_data   (prog_data),
    .if_id       (if_id)
  );

  decode_unit decode_stage (
    .clk      (clk),
    .rst_n    (rst_n),
    .if_id    (if_id),
    .redirect (redirect),
    .rdata_a  (rdata_a),
    .rdata_b  (rdata_b),
    .raddr_a  (raddr_a),
    .raddr_b  (raddr_b),
    .stall    (stall),
    .id_ex    (id_ex)
  );

  register_file regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .we       (rf_we),
    .waddr    (mem_wb.dest),
    .wdata    (mem_wb.result),
    .raddr_a  (raddr_a),
    .raddr_b  (raddr_b),
    .rdata_a  (rdata_a),
    .rdata_b  (rdata_b),
    .dbg_addr (dbg_addr),
    .dbg_data (dbg_data)
  );

  execute_unit execute_stage (
    .clk         (clk),
    .rst_n       (rst_n),
    .id_ex       (id_ex),
    .mem_wb      (mem_wb),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .ex_mem      (ex_mem)
  );

  memory_unit memory_stage (
    .clk    (clk),
    .rst_n  (rst_n),
    .ex_mem (ex_mem),
    .mem_wb (mem_wb),
    .halted (halted)
  );

endmodule

`default_nettype wire

// File: tb/processor_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module processor_asserts (
  input logic clk,
  input logic rst_n,
  input logic halted,
  input logic wb_valid,
  input logic stall,
  input logic redirect,
  input logic id_ex_valid
);

  // number of failed checks
  int unsigned failures = 0;

  //////////////////////////////////////////////////
  // halt
  //////////////////////////////////////////////////

  // only a reset edge may clear halted
  halted_sticky: assert property (@(posedge clk) ($past(halted) && $past(rst_n)) |-> halted)
  else begin
    failures++;
    $error("halted fell while reset was inactive");
  end

  no_wb_after_halt: assert property (@(posedge clk) halted |-> !wb_valid)
  else begin
    failures++;
    $error("writeback retired after halted");
  end

  //////////////////////////////////////////////////
  // pipeline control
  //////////////////////////////////////////////////

  quiet_after_reset: assert property (@(posedge clk)
    (!$past(rst_n) && rst_n) |-> (!stall && !redirect))
  else begin
    failures++;
    $error("stall or redirect high in the first cycle after reset");
  end

  // both younger items are flushed on a taken branch
  flush_on_redirect: assert property (@(posedge clk) redirect |=> !id_ex_valid)
  else begin
    failures++;
    $error("valid ID/EX item right after a redirect");
  end

endmodule

bind processor processor_asserts asserts0 (
  .clk         (clk),
  .rst_n       (rst_n),
  .halted      (halted),
  .wb_valid    (wb_valid),
  .stall       (stall),
  .redirect    (redirect),
  .id_ex_valid (id_ex.valid)
);

`default_nettype wire

// File: tb/processor_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_settings.svh"

module processor_tb;

  localparam int NUM_PROGS  = 5;
  localparam int IMEM_WORDS = 2**`CPU_IMEM_ADDR_BITS;
  localparam int DMEM_WORDS = 2**`CPU_DMEM_ADDR_BITS;
  localparam int NUM_REGS   = 2**`CPU_REG_ADDR_BITS;

  // one retired register write
  typedef struct packed {
    isa_pkg::reg_idx_t idx;
    isa_pkg::data_t    data;
  } wb_rec_t;

  logic              clk;
  logic              rst_n;
  logic              prog_we;
  isa_pkg::pc_t      prog_addr;
  isa_pkg::inst_t    prog_data;
  isa_pkg::reg_idx_t dbg_addr;
  isa_pkg::data_t    dbg_data;
  logic              wb_valid;
  isa_pkg::reg_idx_t wb_reg;
  isa_pkg::data_t    wb_data;
  logic              halted;

  isa_pkg::inst_t prog_words [NUM_PROGS][IMEM_WORDS];
  int             prog_len [NUM_PROGS];
  wb_rec_t        exp_q [$];
  wb_rec_t        expected_wb;
  isa_pkg::data_t model_regs [NUM_REGS];
  int             cycle_count;
  int             cycle_limit;
  int             wb_checked;
  int             value_errors;
  int             missing_errors;
  int             extra_errors;

  processor dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .dbg_addr  (dbg_addr),
    .dbg_data  (dbg_data),
    .wb_valid  (wb_valid),
    .wb_reg    (wb_reg),
    .wb_data   (wb_data),
    .halted    (halted)
  );

  always #20 clk = ~clk;

  //////////////////////////////////////////////////
  // program construction
  //////////////////////////////////////////////////

  function automatic isa_pkg::inst_t r_type(input isa_pkg::opcode_e op, input int rd,
                                            input int rs, input int rt);
    return {op, isa_pkg::reg_idx_t'(rs), isa_pkg::reg_idx_t'(rt),
            isa_pkg::reg_idx_t'(rd), 3'b000};
  endfunction

  // rt is the target of addi/lw and the data of sw
  function automatic isa_pkg::inst_t i_type(input isa_pkg::opcode_e op, input int rt,
                                            input int rs, input int imm);
    return {op, isa_pkg::reg_idx_t'(rs), isa_pkg::reg_idx_t'(rt), isa_pkg::imm_t'(imm)};
  endfunction

  function automatic void add_word(input int id, input isa_pkg::inst_t inst);
    prog_words[id][prog_len[id]] = inst;
    prog_len[id]++;
  endfunction

  task automatic build_random(input int id);
    isa_pkg::opcode_e op;
    int               i;
    int               a;
    int               b;
    int               c;
    for (i = 0; i < 40; i++) begin
      // add through sw are codes 1 to 8
      op = isa_pkg::opcode_e'(4'($urandom % 8 + 1));
      a  = $urandom % NUM_REGS;
      b  = $urandom % NUM_REGS;
      c  = $urandom % 64;
      if (op <= isa_pkg::OP_SLT) begin
        add_word(id, r_type(op, a, b, c % NUM_REGS));
      end else begin
        add_word(id, i_type(op, a, b, c));
      end
    end
    add_word(id, i_type(isa_pkg::OP_HALT, 0, 0, 0));
  endtask

  task automatic build_programs();
    foreach (prog_len[i]) prog_len[i] = 0;
    // dependent chains, both forwarding paths
    add_word(0, i_type(isa_pkg::OP_ADDI, 1, 0, 5));
    add_word(0, i_type(isa_pkg::OP_ADDI, 2, 1, 3));
    add_word(0, r_type(isa_pkg::OP_ADD, 3, 1, 2));
    add_word(0, r_type(isa_pkg::OP_SUB, 4, 3, 1));
    add_word(0, r_type(isa_pkg::OP_AND, 5, 4, 3));
    add_word(0, r_type(isa_pkg::OP_OR, 6, 5, 2));
    add_word(0, r_type(isa_pkg::OP_SLT, 7, 1, 3));
    add_word(0, r_type(isa_pkg::OP_ADD, 1, 1, 1));
    add_word(0, i_type(isa_pkg::OP_HALT, 0, 0, 0));
    // store, load and load-use pairs
    add_word(1, i_type(isa_pkg::OP_ADDI, 1, 0, 9));
    add_word(1, i_type(isa_pkg::OP_ADDI, 2, 0, 20));
    add_word(1, i_type(isa_pkg::OP_SW, 1, 2, 3));
    add_word(1, i_type(isa_pkg::OP_LW, 3, 2, 3));
    add_word(1, r_type(isa_pkg::OP_ADD, 4, 3, 1));
    add_word(1, i_type(isa_pkg::OP_LW, 5, 2, 3));
    add_word(1, i_type(isa_pkg::OP_SW, 5, 2, 4));
    add_word(1, i_type(isa_pkg::OP_LW, 6, 2, 4));
    add_word(1, r_type(isa_pkg::OP_SUB, 7, 6, 4));
    add_word(1, r_type(isa_pkg::OP_SLT, 1, 7, 0));
    add_word(1, i_type(isa_pkg::OP_HALT, 0, 0, 0));
    // branches taken and not taken, then a jump
    add_word(2, i_type(isa_pkg::OP_ADDI, 1, 0, 4));
    add_word(2, i_type(isa_pkg::OP_ADDI, 2, 0, 4));
    add_word(2, i_type(isa_pkg::OP_BEQ, 2, 1, 5));
    add_word(2, i_type(isa_pkg::OP_ADDI, 3, 0, 1));
    add_word(2, i_type(isa_pkg::OP_ADDI, 4, 0, 1));
    add_word(2, i_type(isa_pkg::OP_BNE, 2, 1, 8));
    add_word(2, i_type(isa_pkg::OP_ADDI, 5, 0, 7));
    add_word(2, i_type(isa_pkg::OP_BEQ, 5, 1, 3));
    add_word(2, i_type(isa_pkg::OP_BNE, 5, 1, 11));
    add_word(2, i_type(isa_pkg::OP_ADDI, 6, 0, 1));
    add_word(2, i_type(isa_pkg::OP_ADDI, 6, 0, 2));
    add_word(2, i_type(isa_pkg::OP_J, 0, 0, 14));
    add_word(2, i_type(isa_pkg::OP_ADDI, 7, 0, 9));
    add_word(2, i_type(isa_pkg::OP_ADDI, 7, 0, 10));
    add_word(2, i_type(isa_pkg::OP_ADDI, 3, 3, 2));
    add_word(2, i_type(isa_pkg::OP_HALT, 0, 0, 0));
    // writes to r0 must vanish
    add_word(3, i_type(isa_pkg::OP_ADDI, 0, 0, 7));
    add_word(3, i_type(isa_pkg::OP_ADDI, 1, 0, 3));
    add_word(3, r_type(isa_pkg::OP_ADD, 0, 1, 1));
    add_word(3, r_type(isa_pkg::OP_ADD, 2, 0, 1));
    add_word(3, i_type(isa_pkg::OP_LW, 0, 1, 0));
    add_word(3, r_type(isa_pkg::OP_OR, 3, 2, 0));
    add_word(3, i_type(isa_pkg::OP_HALT, 0, 0, 0));
    build_random(4);
  endtask

  //////////////////////////////////////////////////
  // ISA model
  //////////////////////////////////////////////////

  // runs to halt, queues every non-r0 write, returns instructions executed
  function automatic int run_isa(input int id);
    isa_pkg::data_t                 regs [NUM_REGS];
    isa_pkg::data_t                 dmem [DMEM_WORDS];
    isa_pkg::inst_t                 inst;
    isa_pkg::opcode_e               op;
    isa_pkg::data_t                 value;
    isa_pkg::data_t                 sum;
    logic [`CPU_DMEM_ADDR_BITS-1:0] addr;
    int                             pc;
    int                             rs;
    int                             rt;
    int                             imm;
    int                             dest;
    int                             steps;
    foreach (regs[i]) regs[i] = '0;
    foreach (dmem[i]) dmem[i] = '0;
    pc    = 0;
    steps = 0;
    op    = isa_pkg::OP_NOP;
    while (op != isa_pkg::OP_HALT && steps < 1000) begin
      inst  = prog_words[id][pc];
      op    = isa_pkg::opcode_e'(inst[15:12]);
      rs    = inst[11:9];
      rt    = inst[8:6];
      imm   = inst[5:0];
      sum   = regs[rs] + isa_pkg::data_t'(imm);
      addr  = sum[`CPU_DMEM_ADDR_BITS-1:0];
      pc    = (pc + 1) % IMEM_WORDS;
      steps++;
      dest  = 0;
      case (op)
        isa_pkg::OP_ADD:  value = regs[rs] + regs[rt];
        isa_pkg::OP_SUB:  value = regs[rs] - regs[rt];
        isa_pkg::OP_AND:  value = regs[rs] & regs[rt];
        isa_pkg::OP_OR:   value = regs[rs] | regs[rt];
        isa_pkg::OP_SLT:  value = ($signed(regs[rs]) < $signed(regs[rt])) ? 16'd1 : 16'd0;
        isa_pkg::OP_ADDI: value = sum;
        isa_pkg::OP_LW:   value = dmem[addr];
        default:          value = '0;
      endcase
      if (op >= isa_pkg::OP_ADD && op <= isa_pkg::OP_SLT) begin
        dest = inst[5:3];
      end else if (op == isa_pkg::OP_ADDI || op == isa_pkg::OP_LW) begin
        dest = rt;
      end
      if (op == isa_pkg::OP_SW) begin
        dmem[addr] = regs[rt];
      end
      if ((op == isa_pkg::OP_J)
          || (op == isa_pkg::OP_BEQ && regs[rs] == regs[rt])
          || (op == isa_pkg::OP_BNE && regs[rs] != regs[rt])) begin
        pc = imm;
      end
      if (dest != 0) begin
        regs[dest] = value;
        exp_q.push_back('{idx: isa_pkg::reg_idx_t'(dest), data: value});
      end
    end
    foreach (model_regs[i]) model_regs[i] = regs[i];
    return steps;
  endfunction

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  task automatic check_reg_idx(input string name, input isa_pkg::reg_idx_t got,
                               input isa_pkg::reg_idx_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("Fail %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_data(input string name, input isa_pkg::data_t got,
                            input isa_pkg::data_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("Fail %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  function automatic int error_total();
    return value_errors + missing_errors + extra_errors + int'(dut0.asserts0.failures);
  endfunction

  task automatic print_counts();
    $display("summary: %0d writebacks checked, %0d value errors, %0d missing, %0d extra, %0d %s",
             wb_checked, value_errors, missing_errors, extra_errors,
             dut0.asserts0.failures, "assertion failures");
  endtask

  // every retired write against the model, in order
  always @(posedge clk) begin
    if (rst_n && wb_valid) begin
      if (exp_q.size() == 0) begin
        extra_errors++;
        $display("error at %0t: unexpected writeback of %h to r%0d", $time, wb_data, wb_reg);
      end else begin
        expected_wb = exp_q.pop_front();
        check_reg_idx("wb_reg", wb_reg, expected_wb.idx);
        check_data("wb_data", wb_data, expected_wb.data);
        wb_checked++;
      end
    end
  end

  always @(posedge clk) begin
    if (rst_n) begin
      cycle_count++;
      if (cycle_count > cycle_limit) begin
        $display("timeout: the programs did not finish within %0d cycles", cycle_limit);
        print_counts();
        $display("FAIL: see errors above");
        $finish;
      end
    end
  end

  //////////////////////////////////////////////////
  // test flow
  //////////////////////////////////////////////////

  task automatic run_program(input int id);
    int i;
    int load_cycles;
    void'(run_isa(id));
    // reset lasts 16 cycles, longer if the program needs it
    load_cycles = (prog_len[id] > 16) ? prog_len[id] : 16;
    for (i = 0; i < load_cycles; i++) begin
      @(negedge clk);
      rst_n     = 1'b0;
      prog_we   = (i < prog_len[id]);
      prog_addr = isa_pkg::pc_t'(i);
      prog_data = prog_words[id][i];
    end
    @(negedge clk);
    prog_we = 1'b0;
    rst_n   = 1'b1;
    while (!halted) @(negedge clk);
    // quiet period, nothing may retire after halt
    repeat (6) @(negedge clk);
    if (exp_q.size() != 0) begin
      missing_errors += exp_q.size();
      $display("error: program %0d ended with %0d expected writebacks missing",
               id, exp_q.size());
      exp_q.delete();
    end
    for (i = 0; i < NUM_REGS; i++) begin
      @(negedge clk);
      dbg_addr = isa_pkg::reg_idx_t'(i);
      @(posedge clk);
      check_data($sformatf("dbg_data r%0d", i), dbg_data, model_regs[i]);
    end
  endtask

  initial begin
    int id;
    clk            = 1'b0;
    rst_n          = 1'b0;
    prog_we        = 1'b0;
    prog_addr      = '0;
    prog_data      = '0;
    dbg_addr       = '0;
    cycle_count    = 0;
    cycle_limit    = 0;
    wb_checked     = 0;
    value_errors   = 0;
    missing_errors = 0;
    extra_errors   = 0;
    void'($urandom(32'h94bbb885));
    build_programs();
    for (id = 0; id < NUM_PROGS; id++) begin
      cycle_limit += 3 * run_isa(id) + 40;
    end
    exp_q.delete();
    for (id = 0; id < NUM_PROGS; id++) begin
      run_program(id);
    end
    print_counts();
    if (error_total() == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+logic
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/fetch_unit.sv
logic/register_file.sv
logic/decode_unit.sv
logic/execute_unit.sv
logic/memory_unit.sv
logic/processor.sv
tb/processor_asserts.sv
tb/processor_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = processor_tb
FILELIST = sources.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = FAIL: see errors above

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
